// File: bender.yml
package:
  name: pipe_ctrl

sources:
  # package first, then the stages, then the top level
  - files:
      - src/pipe_ctrl_pkg.sv
      - src/fetch_decode_fsm.sv
      - src/mem_access_fsm.sv
      - src/write_back_fsm.sv
      - src/pipe_ctrl.sv

  - target: test
    files:
      - tests/tb_clock_gen.sv
      - tests/tb_pipe_ctrl.sv

// File: pipe_ctrl.f
src/pipe_ctrl_pkg.sv
src/fetch_decode_fsm.sv
src/mem_access_fsm.sv
src/write_back_fsm.sv
src/pipe_ctrl.sv
tests/tb_clock_gen.sv
tests/tb_pipe_ctrl.sv

// File: tests/tb_pipe_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module tb_pipe_ctrl
    import pipe_ctrl_pkg::*;
();

    localparam int N_ROWS = 13;
    // 40 cycles per row plus a few for reset
    localparam int WATCHDOG_NS = (N_ROWS * 40 + 8) * 40;

    // event counter slots
    localparam int EV_ALU  = 0;
    localparam int EV_ILL  = 1;
    localparam int EV_IMM  = 2;
    localparam int EV_RW   = 3;
    localparam int EV_FM   = 4;
    localparam int EV_DREQ = 5;
    localparam int EV_DW   = 6;
    localparam int EV_IO   = 7;

    logic      clk;
    logic      rst;
    opcode_u   opcode;
    logic      instr_valid;
    mem_sel_t  mem_sel;
    wb_sel_t   wb_sel;
    logic      data_valid;
    logic      io_ack;
    logic      instr_req;
    logic      alu_en;
    alu_func_t alu_func;
    alu_mode_t alu_mode;
    logic      imm_load;
    logic      illegal_op;
    logic      data_req;
    logic      data_write;
    logic      io_req;
    logic      reg_write;
    logic      wb_from_mem;

    // stimulus table
    string     row_name [N_ROWS];
    logic [5:0] row_op  [N_ROWS];
    mem_sel_t  row_msel [N_ROWS];
    wb_sel_t   row_wsel [N_ROWS];
    alu_func_t row_func [N_ROWS];
    alu_mode_t row_mode [N_ROWS];
    logic      row_alu  [N_ROWS];
    logic      row_ill  [N_ROWS];
    logic      row_imm  [N_ROWS];
    int        row_rw   [N_ROWS];
    int        row_fm   [N_ROWS];
    int        n_rows = 0;

    int        cyc = 0;
    int        ev_cnt [0:7] = '{default: 0};
    int        alu_cyc;
    int        ill_cyc;
    int        imm_cyc;
    alu_func_t seen_func;
    alu_mode_t seen_mode;
    logic      dreq_prev;
    logic      dvalid_prev;
    logic      ioreq_prev;
    logic      ioack_prev;

    string      cur_name = "reset";
    int         errors = 0;
    int         mon_errors = 0;
    int         tests_run = 0;
    int         tests_failed = 0;
    logic [7:0] lfsr_state = 8'd87;
    int         data_delay = 0;
    int         rise_delay = 0;
    int         fall_delay = 0;
    event       io_start;

    tb_clock_gen i_clk_gen (
        .clk (clk),
        .rst (rst)
    );

    pipe_ctrl i_dut (
        .clk         (clk),
        .rst         (rst),
        .opcode      (opcode),
        .instr_valid (instr_valid),
        .mem_sel     (mem_sel),
        .wb_sel      (wb_sel),
        .data_valid  (data_valid),
        .io_ack      (io_ack),
        .instr_req   (instr_req),
        .alu_en      (alu_en),
        .alu_func    (alu_func),
        .alu_mode    (alu_mode),
        .imm_load    (imm_load),
        .illegal_op  (illegal_op),
        .data_req    (data_req),
        .data_write  (data_write),
        .io_req      (io_req),
        .reg_write   (reg_write),
        .wb_from_mem (wb_from_mem)
    );

    ////////////////////////////////////////////////////////////
    // random delays, helpers and compares
    ////////////////////////////////////////////////////////////

    // galois form with taps for x^8 + x^6 + x^5 + x^4 + 1
    function automatic logic [7:0] lfsr_next(input logic [7:0] s);
        return s[0] ? ((s >> 1) ^ 8'hB8) : (s >> 1);
    endfunction

    // two bits give 0..3 cycles
    function automatic int random_delay();
        int d;
        d = 0;
        for (int b = 0; b < 2; b++)
        begin
            d = (d << 1) | lfsr_state[0];
            lfsr_state = lfsr_next(lfsr_state);
        end
        return d;
    endfunction

    function automatic int total_errors();
        return errors + mon_errors;
    endfunction

    task automatic add_row(input string name, input logic [5:0] op, input mem_sel_t msel,
                           input wb_sel_t wsel, input alu_func_t func, input alu_mode_t mode,
                           input logic is_alu, input logic ill, input logic imm,
                           input int rw, input int fm);
        row_name[n_rows] = name;
        row_op[n_rows]   = op;
        row_msel[n_rows] = msel;
        row_wsel[n_rows] = wsel;
        row_func[n_rows] = func;
        row_mode[n_rows] = mode;
        row_alu[n_rows]  = is_alu;
        row_ill[n_rows]  = ill;
        row_imm[n_rows]  = imm;
        row_rw[n_rows]   = rw;
        row_fm[n_rows]   = fm;
        n_rows++;
    endtask

    task automatic fill_table();
        // name, opcode, mem_sel, wb_sel, func, mode, alu, illegal, imm, reg_write, from_mem
        add_row("alu_f0_m0", 6'o00, MEM_NONE,  WB_ALU,  3'd0, 2'd0, 1, 0, 0, 1, 0);
        add_row("alu_f3_m2", 6'o16, MEM_LOAD,  WB_MEM,  3'd3, 2'd2, 1, 0, 0, 1, 1);
        add_row("alu_f7_m0", 6'o34, MEM_STORE, WB_ALU,  3'd7, 2'd0, 1, 0, 0, 1, 0);
        add_row("alu_f5_m2", 6'o26, MEM_IO_IN, WB_NONE, 3'd5, 2'd2, 1, 0, 0, 0, 0);
        add_row("imm_f1_m1", 6'o05, MEM_NONE,  WB_ALU,  3'd1, 2'd1, 1, 0, 1, 1, 0);
        add_row("imm_f6_m3", 6'o33, MEM_LOAD,  WB_MEM,  3'd6, 2'd3, 1, 0, 1, 1, 1);
        add_row("imm_f2_m1", 6'o11, MEM_STORE, WB_NONE, 3'd2, 2'd1, 1, 0, 1, 0, 0);
        add_row("imm_f7_m3", 6'o37, MEM_IO_IN, WB_ALU,  3'd7, 2'd3, 1, 0, 1, 1, 0);
        add_row("other_40",  6'o40, MEM_LOAD,  WB_MEM,  3'd0, 2'd0, 0, 0, 0, 1, 1);
        add_row("other_55",  6'o55, MEM_STORE, WB_ALU,  3'd0, 2'd0, 0, 0, 0, 1, 0);
        // unnamed write-back code 3 acts as none
        add_row("other_47",  6'o47, MEM_IO_IN, wb_sel_t'(2'd3), 3'd0, 2'd0, 0, 0, 0, 0, 0);
        add_row("illegal_56", 6'o56, MEM_LOAD,  WB_ALU, 3'd0, 2'd0, 0, 1, 0, 0, 0);
        add_row("illegal_77", 6'o77, MEM_IO_IN, WB_MEM, 3'd0, 2'd0, 0, 1, 0, 0, 0);
    endtask

    task automatic check_alu(input string name, input alu_func_t exp_func,
                             input alu_func_t act_func, input alu_mode_t exp_mode,
                             input alu_mode_t act_mode);
        if (act_func !== exp_func)
        begin
            $display("[FAIL] %s: alu_func expected %0d, got %0d", name, exp_func, act_func);
            errors++;
        end
        if (act_mode !== exp_mode)
        begin
            $display("[FAIL] %s: alu_mode expected %0d, got %0d", name, exp_mode, act_mode);
            errors++;
        end
    endtask

    task automatic check_flag(input string name, input string what, input logic exp,
                              input logic act);
        if (act !== exp)
        begin
            $display("[FAIL] %s: %s expected %b, got %b", name, what, exp, act);
            errors++;
        end
    endtask

    task automatic check_count(input string name, input string what, input int exp,
                               input int act);
        if (act != exp)
        begin
            $display("[FAIL] %s: %s expected %0d, got %0d", name, what, exp, act);
            errors++;
        end
    endtask

    task automatic report_test(input string name, input int errs_before);
        tests_run++;
        if (total_errors() == errs_before)
            $display("test %-12s ok", name);
        else
        begin
            tests_failed++;
            $display("test %-12s %0d errors", name, total_errors() - errs_before);
        end
    endtask

    // waits for instr_req and answers with one instr_valid cycle
    task automatic fetch_word(output int req_cyc, output int valid_cyc);
        do
            @(negedge clk);
        while (!instr_req);
        req_cyc = cyc;
        @(posedge clk);
        instr_valid <= 1'b1;
        @(negedge clk);
        valid_cyc = cyc;
        @(posedge clk);
        instr_valid <= 1'b0;
    endtask

    ////////////////////////////////////////////////////////////
    // cycle count, monitor and responders
    ////////////////////////////////////////////////////////////

    always @(posedge clk)
        cyc <= cyc + 1;

    // outputs sampled mid-cycle
    always @(negedge clk)
    begin
        if (!rst)
        begin
            if (alu_en)
            begin
                ev_cnt[EV_ALU]++;
                alu_cyc   = cyc;
                seen_func = alu_func;
                seen_mode = alu_mode;
            end
            if (illegal_op)
            begin
                ev_cnt[EV_ILL]++;
                ill_cyc = cyc;
            end
            if (imm_load)
            begin
                ev_cnt[EV_IMM]++;
                imm_cyc = cyc;
            end
            if (reg_write)
                ev_cnt[EV_RW]++;
            if (wb_from_mem)
                ev_cnt[EV_FM]++;
            if (data_req)
                ev_cnt[EV_DREQ]++;
            if (data_req && data_write)
                ev_cnt[EV_DW]++;
            if (io_req)
                ev_cnt[EV_IO]++;

            if (wb_from_mem && !reg_write)
            begin
                $display("error in %s: wb_from_mem high without reg_write", cur_name);
                mon_errors++;
            end
            if (dreq_prev && !data_req && !dvalid_prev)
            begin
                $display("error in %s: data_req dropped before data_valid", cur_name);
                mon_errors++;
            end
            if (dreq_prev && data_req && dvalid_prev)
            begin
                $display("error in %s: data_req still held after data_valid", cur_name);
                mon_errors++;
            end
            if (io_req && !ioreq_prev && !ioack_prev)
            begin
                $display("error in %s: io_req rose before io_ack was high", cur_name);
                mon_errors++;
            end
            if (!io_req && ioreq_prev && ioack_prev)
            begin
                $display("error in %s: io_req dropped while io_ack was still high", cur_name);
                mon_errors++;
            end
        end
        dreq_prev   = data_req;
        dvalid_prev = data_valid;
        ioreq_prev  = io_req;
        ioack_prev  = io_ack;
    end

    initial
    begin : data_responder
        data_valid = 1'b0;
        forever
        begin
            @(negedge clk);
            if (data_req)
            begin
                @(posedge clk);
                repeat (data_delay) @(posedge clk);
                data_valid <= 1'b1;
                @(posedge clk);
                data_valid <= 1'b0;
            end
        end
    end

    // four-phase device side raises ack first
    initial
    begin : io_responder
        io_ack = 1'b0;
        forever
        begin
            @(io_start);
            @(posedge clk);
            repeat (rise_delay) @(posedge clk);
            io_ack <= 1'b1;
            do
                @(negedge clk);
            while (!io_req);
            @(posedge clk);
            repeat (fall_delay) @(posedge clk);
            io_ack <= 1'b0;
            do
                @(negedge clk);
            while (io_req);
        end
    end

    initial
    begin : watchdog
        #(WATCHDOG_NS);
        $display("timeout: the run did not finish within %0d ns", WATCHDOG_NS);
        $display("sim failed");
        $finish;
    end

    ////////////////////////////////////////////////////////////
    // main sequence
    ////////////////////////////////////////////////////////////

    initial
    begin : main
        int   t_cyc;
        int   u_cyc;
        int   req_cyc;
        int   errs_before;
        int   base [0:7];
        int   got [0:7];
        logic issued;
        logic exp_dreq;
        logic exp_store;
        logic exp_io;

        opcode.raw  = 6'o00;
        instr_valid = 1'b0;
        mem_sel     = MEM_NONE;
        wb_sel      = WB_NONE;
        fill_table();

        // reset state
        do
            @(negedge clk);
        while (rst);
        errs_before = total_errors();
        check_flag("reset", "alu_en", 1'b0, alu_en);
        check_flag("reset", "imm_load", 1'b0, imm_load);
        check_flag("reset", "illegal_op", 1'b0, illegal_op);
        check_flag("reset", "reg_write", 1'b0, reg_write);
        check_flag("reset", "wb_from_mem", 1'b0, wb_from_mem);
        check_flag("reset", "data_req", 1'b0, data_req);
        check_flag("reset", "io_req", 1'b0, io_req);
        @(negedge clk);
        check_flag("reset", "instr_req", 1'b1, instr_req);
        report_test("reset", errs_before);

        for (int i = 0; i < n_rows; i++)
        begin
            errs_before = total_errors();
            issued    = !row_ill[i];
            exp_dreq  = issued && (row_msel[i] == MEM_LOAD || row_msel[i] == MEM_STORE);
            exp_store = issued && (row_msel[i] == MEM_STORE);
            exp_io    = issued && (row_msel[i] == MEM_IO_IN);
            data_delay = random_delay();
            rise_delay = random_delay();
            fall_delay = random_delay();

            @(posedge clk);
            cur_name = row_name[i];
            opcode.raw <= row_op[i];
            mem_sel    <= row_msel[i];
            wb_sel     <= row_wsel[i];
            base = ev_cnt;

            fetch_word(req_cyc, t_cyc);
            if (row_imm[i])
                fetch_word(req_cyc, u_cyc);

            // device delays count from the last instruction word
            if (exp_io)
                -> io_start;

            // write-back has landed once fetch asks again
            do
                @(negedge clk);
            while (!instr_req);
            repeat (2) @(negedge clk);

            for (int k = 0; k < 8; k++)
                got[k] = ev_cnt[k] - base[k];

            check_count(row_name[i], "alu_en pulses", row_alu[i], got[EV_ALU]);
            if (row_alu[i] && got[EV_ALU] == 1)
            begin
                check_count(row_name[i], "alu_en delay", 2, alu_cyc - t_cyc);
                check_alu(row_name[i], row_func[i], seen_func, row_mode[i], seen_mode);
            end
            check_count(row_name[i], "illegal_op pulses", row_ill[i], got[EV_ILL]);
            if (row_ill[i] && got[EV_ILL] == 1)
                check_count(row_name[i], "illegal_op delay", 2, ill_cyc - t_cyc);
            check_count(row_name[i], "imm_load pulses", row_imm[i], got[EV_IMM]);
            if (row_imm[i])
            begin
                check_count(row_name[i], "second instr_req delay", 3, req_cyc - t_cyc);
                check_count(row_name[i], "imm_load delay", 1, imm_cyc - u_cyc);
            end
            check_count(row_name[i], "reg_write pulses", row_rw[i], got[EV_RW]);
            check_count(row_name[i], "wb_from_mem pulses", row_fm[i], got[EV_FM]);
            check_flag(row_name[i], "data_req seen", exp_dreq, got[EV_DREQ] != 0);
            check_flag(row_name[i], "data_write seen", exp_store, got[EV_DW] != 0);
            if (exp_store)
                check_count(row_name[i], "data_write cycles", got[EV_DREQ], got[EV_DW]);
            check_flag(row_name[i], "io_req seen", exp_io, got[EV_IO] != 0);
            report_test(row_name[i], errs_before);
        end

        $display("tests %0d, passed %0d, failed %0d, errors %0d",
                 tests_run, tests_run - tests_failed, tests_failed, total_errors());
        if (total_errors() == 0)
            $display("sim passed");
        else
            $display("sim failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: tests/tb_clock_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
    output logic clk,
    output logic rst
);

    // 40 ns period
    initial
    begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // reset held over four rising edges
    initial
    begin
        rst = 1'b1;
        repeat (4) @(posedge clk);
        rst <= 1'b0;
    end

endmodule

`default_nettype wire

// File: src/pipe_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module pipe_ctrl
    import pipe_ctrl_pkg::*;
(
    input  wire logic     clk,
    input  wire logic     rst,
    input  wire opcode_u  opcode,
    input  wire logic     instr_valid,
    input  wire mem_sel_t mem_sel,
    input  wire wb_sel_t  wb_sel,
    input  wire logic     data_valid,
    input  wire logic     io_ack,
    output logic          instr_req,
    output logic          alu_en,
    output alu_func_t     alu_func,
    output alu_mode_t     alu_mode,
    output logic          imm_load,
    output logic          illegal_op,
    output logic          data_req,
    output logic          data_write,
    output logic          io_req,
    output logic          reg_write,
    output logic          wb_from_mem
);

    // stage to stage handshakes
    logic issue;
    logic mem_idle;
    logic mem_done;
    logic wb_idle;

    ////////////////////////////////////////////////////////////
    // stages
    ////////////////////////////////////////////////////////////

    fetch_decode_fsm i_fetch (
        .clk         (clk),
        .rst         (rst),
        .opcode      (opcode),
        .instr_valid (instr_valid),
        .mem_idle    (mem_idle),
        .instr_req   (instr_req),
        .issue       (issue),
        .alu_en      (alu_en),
        .alu_func    (alu_func),
        .alu_mode    (alu_mode),
        .imm_load    (imm_load),
        .illegal_op  (illegal_op)
    );

    mem_access_fsm i_mem (
        .clk        (clk),
        .rst        (rst),
        .issue      (issue),
        .mem_sel    (mem_sel),
        .wb_idle    (wb_idle),
        .data_valid (data_valid),
        .io_ack     (io_ack),
        .mem_idle   (mem_idle),
        .mem_done   (mem_done),
        .data_req   (data_req),
        .data_write (data_write),
        .io_req     (io_req)
    );

    write_back_fsm i_wb (
        .clk         (clk),
        .rst         (rst),
        .mem_done    (mem_done),
        .wb_sel      (wb_sel),
        .wb_idle     (wb_idle),
        .reg_write   (reg_write),
        .wb_from_mem (wb_from_mem)
    );

endmodule

`default_nettype wire

// File: src/write_back_fsm.sv
`timescale 1ns/1ps
`default_nettype none

module write_back_fsm
    import pipe_ctrl_pkg::*;
(
    input  wire logic    clk,
    input  wire logic    rst,
    input  wire logic    mem_done,
    input  wire wb_sel_t wb_sel,
    output logic         wb_idle,
    output logic         reg_write,
    output logic         wb_from_mem
);

    typedef enum logic [1:0] {
        W_IDLE,
        W_SELECT,
        W_WRITE
    } wb_state_t;

    wb_state_t state;
    wb_sel_t   sel_q;

    ////////////////////////////////////////////////////////////
    // select latch and sequencing
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state <= W_IDLE;
            sel_q <= WB_NONE;
        end
        else
        begin
            case (state)
                W_IDLE:
                    if (mem_done)
                    begin
                        state <= W_SELECT;
                        sel_q <= wb_sel;
                    end
                // unnamed code 3 drops back like WB_NONE
                W_SELECT:
                    if (sel_q == WB_ALU || sel_q == WB_MEM)
                        state <= W_WRITE;
                    else
                        state <= W_IDLE;
                default:
                    state <= W_IDLE;
            endcase
        end
    end

    assign wb_idle     = (state == W_IDLE);
    assign reg_write   = (state == W_WRITE);
    assign wb_from_mem = (state == W_WRITE) && (sel_q == WB_MEM);

    a_no_write_idle: assert property (
        @(posedge clk) disable iff (rst)
        reg_write |-> !wb_idle && $past(mem_done, 2)
                   && ($past(wb_sel, 2) == WB_ALU || $past(wb_sel, 2) == WB_MEM)
    );

endmodule

`default_nettype wire

// File: src/mem_access_fsm.sv
`timescale 1ns/1ps
`default_nettype none

module mem_access_fsm
    import pipe_ctrl_pkg::*;
(
    input  wire logic     clk,
    input  wire logic     rst,
    input  wire logic     issue,
    input  wire mem_sel_t mem_sel,
    input  wire logic     wb_idle,
    input  wire logic     data_valid,
    input  wire logic     io_ack,
    output logic          mem_idle,
    output logic          mem_done,
    output logic          data_req,
    output logic          data_write,
    output logic          io_req
);

    typedef enum logic [2:0] {
        M_IDLE,
        M_WB_WAIT,
        M_REQ,
        M_IO_HIGH,
        M_IO_HOLD,
        M_DONE
    } mem_state_t;

    mem_state_t state;
    mem_state_t next_state;
    mem_sel_t   sel_q;

    ////////////////////////////////////////////////////////////
    // state register and transitions
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk)
    begin
        if (rst)
            state <= M_IDLE;
        else
            state <= next_state;
    end

    always_ff @(posedge clk)
    begin
        if (rst)
            sel_q <= MEM_NONE;
        else if (issue)
            sel_q <= mem_sel;
    end

    always_comb
    begin
        next_state = state;
        case (state)
            M_IDLE:
                if (issue)
                begin
                    case (mem_sel)
                        MEM_LOAD,
                        MEM_STORE: next_state = M_WB_WAIT;
                        MEM_IO_IN: next_state = M_IO_HIGH;
                        default:   next_state = M_DONE;
                    endcase
                end
            // request goes out only once write-back is free
            M_WB_WAIT:
                if (wb_idle)
                    next_state = data_valid ? M_DONE : M_REQ;
            M_REQ:
                if (data_valid)
                    next_state = M_DONE;
            // device raises ack first, then we answer and hold
            M_IO_HIGH:
                if (io_ack)
                    next_state = M_IO_HOLD;
            M_IO_HOLD:
                if (!io_ack)
                    next_state = M_DONE;
            M_DONE:
                if (wb_idle)
                    next_state = M_IDLE;
            default:
                next_state = M_IDLE;
        endcase
    end

    ////////////////////////////////////////////////////////////
    // outputs
    ////////////////////////////////////////////////////////////

    assign mem_idle   = (state == M_IDLE);
    assign mem_done   = (state == M_DONE) && wb_idle;
    assign io_req     = (state == M_IO_HOLD);

    // level request, held until the data side answers
    assign data_req   = (state == M_REQ) || ((state == M_WB_WAIT) && wb_idle);
    assign data_write = data_req && (sel_q == MEM_STORE);

    a_issue_when_idle: assert property (
        @(posedge clk) disable iff (rst)
        issue |-> mem_idle
    );

    a_req_held_to_valid: assert property (
        @(posedge clk) disable iff (rst)
        $fell(data_req) |-> $past(data_valid)
    );

endmodule

`default_nettype wire

// File: src/fetch_decode_fsm.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_decode_fsm
    import pipe_ctrl_pkg::*;
(
    input  wire logic      clk,
    input  wire logic      rst,
    input  wire opcode_u   opcode,
    input  wire logic      instr_valid,
    input  wire logic      mem_idle,
    output logic           instr_req,
    output logic           issue,
    output logic           alu_en,
    output alu_func_t      alu_func,
    output alu_mode_t      alu_mode,
    output logic           imm_load,
    output logic           illegal_op
);

    typedef enum logic [2:0] {
        F_IDLE,
        F_FETCH,
        F_DECODE,
        F_EXECUTE,
        F_IMM_WAIT,
        F_IMM_LOAD
    } fetch_state_t;

    fetch_state_t state;
    fetch_state_t next_state;

    opcode_u opcode_q;
    logic    is_alu_q;
    logic    is_illegal_q;
    logic    needs_imm_q;

    ////////////////////////////////////////////////////////////
    // state register and transitions
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk)
    begin
        if (rst)
            state <= F_IDLE;
        else
            state <= next_state;
    end

    always_comb
    begin
        next_state = state;
        case (state)
            // hold off until the memory stage can take the next op
            F_IDLE:
                if (mem_idle)
                    next_state = F_FETCH;
            F_FETCH:
                if (instr_valid)
                    next_state = F_DECODE;
            F_DECODE:
                next_state = F_EXECUTE;
            F_EXECUTE:
                if (needs_imm_q)
                    next_state = F_IMM_WAIT;
                else
                    next_state = F_IDLE;
            F_IMM_WAIT:
                if (instr_valid)
                    next_state = F_IMM_LOAD;
            F_IMM_LOAD:
                next_state = F_IDLE;
            default:
                next_state = F_IDLE;
        endcase
    end

    ////////////////////////////////////////////////////////////
    // opcode latch and decode
    ////////////////////////////////////////////////////////////

    // only the first word is an opcode, the immediate is not kept
    always_ff @(posedge clk)
    begin
        if (state == F_FETCH && instr_valid)
            opcode_q <= opcode;
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            is_alu_q     <= 1'b0;
            is_illegal_q <= 1'b0;
            needs_imm_q  <= 1'b0;
        end
        else if (state == F_DECODE)
        begin
            is_alu_q     <= (opcode_q.raw <= ALU_OP_LAST);
            is_illegal_q <= (opcode_q.raw > LEGAL_OP_LAST);
            // odd modes take an immediate word
            needs_imm_q  <= (opcode_q.raw <= ALU_OP_LAST) && opcode_q.alu.mode[0];
        end
    end

    // function and mode stay put until the next opcode is decoded
    always_ff @(posedge clk)
    begin
        if (state == F_DECODE)
        begin
            alu_func <= opcode_q.alu.func;
            alu_mode <= opcode_q.alu.mode;
        end
    end

    ////////////////////////////////////////////////////////////
    // outputs
    ////////////////////////////////////////////////////////////

    assign instr_req  = (state == F_FETCH) || (state == F_IMM_WAIT);
    assign alu_en     = (state == F_EXECUTE) && is_alu_q;
    assign illegal_op = (state == F_EXECUTE) && is_illegal_q;
    assign imm_load   = (state == F_IMM_LOAD);

    // immediate ops issue once the second word is in
    assign issue = ((state == F_EXECUTE) && !is_illegal_q && !needs_imm_q)
                || (state == F_IMM_LOAD);

    a_alu_illegal_excl: assert property (
        @(posedge clk) disable iff (rst)
        !(alu_en && illegal_op)
    );

endmodule

`default_nettype wire

// File: src/pipe_ctrl_pkg.sv
`default_nettype none

package pipe_ctrl_pkg;

    ////////////////////////////////////////////////////////////
    // opcode fields
    ////////////////////////////////////////////////////////////

    // ALU function, opcode bits 4:2
    typedef logic [2:0] alu_func_t;

    // operand mode, opcode bits 1:0
    // modes 1 and 3 carry a second, immediate word
    typedef logic [1:0] alu_mode_t;

    typedef struct packed {
        logic      msb;
        alu_func_t func;
        alu_mode_t mode;
    } alu_view_t;

    // one opcode word, read whole for range checks
    // or split into function and mode for ALU ops
    typedef union packed {
        logic [5:0] raw;
        alu_view_t  alu;
    } opcode_u;

    // opcode map
    // 00..37 octal   ALU operations
    // 40..55 octal   non-ALU, handed straight to the memory stage
    // above 55       illegal
    localparam logic [5:0] ALU_OP_LAST   = 6'o37;
    localparam logic [5:0] LEGAL_OP_LAST = 6'o55;

    ////////////////////////////////////////////////////////////
    // stage select codes
    ////////////////////////////////////////////////////////////

    // sampled by the memory stage on issue
    typedef enum logic [1:0] {
        MEM_NONE  = 2'd0,
        MEM_LOAD  = 2'd1,
        MEM_STORE = 2'd2,
        MEM_IO_IN = 2'd3
    } mem_sel_t;

    // sampled by the write-back stage on mem_done
    // code 3 has no name and behaves as WB_NONE
    typedef enum logic [1:0] {
        WB_NONE = 2'd0,
        WB_ALU  = 2'd1,
        WB_MEM  = 2'd2
    } wb_sel_t;

endpackage

`default_nettype wire
